//--- src.f
hdl/rv32_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/inst_queue.sv
hdl/decode_issue.sv
hdl/execute_units.sv
hdl/result_writeback.sv
hdl/backend_top.sv
sim/tb_backend.sv

//--- Bender.yml
package:
  name: rv32_backend

sources:
  - files:
      - hdl/rv32_isa_pkg.sv
      - hdl/core_ctrl_pkg.sv
      - hdl/inst_queue.sv
      - hdl/decode_issue.sv
      - hdl/execute_units.sv
      - hdl/result_writeback.sv
      - hdl/backend_top.sv
  - target: simulation
    files:
      - sim/tb_backend.sv

//--- sim/tb_backend.sv
`timescale 1ns/1ps

module tb_backend;
    import rv32_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int PROG_LEN       = 120;
    localparam int NUM_REGS       = 6;  // x0..x5 only, so hazards are common
    localparam int TIMEOUT_CYCLES = PROG_LEN * 8 + 100;

    logic                  clk;
    logic                  rst;
    logic                  inst_valid_i;
    logic [XLEN-1:0]       inst_i;
    logic                  full_o;
    logic                  illegal_o;
    logic                  wb_valid_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;
    logic [SEQ_W-1:0]      wb_seq_o;
    logic [REG_ADDR_W-1:0] rf_raddr_i;
    logic [XLEN-1:0]       rf_rdata_o;

    logic [XLEN-1:0]       prog [PROG_LEN];
    logic [XLEN-1:0]       ref_rf [2**REG_ADDR_W];
    logic [REG_ADDR_W-1:0] exp_rd [2**SEQ_W];
    logic [XLEN-1:0]       exp_data [2**SEQ_W];
    int                    prod1 [2**SEQ_W];  // seq of the rs1 producer, -1 if none
    int                    prod2 [2**SEQ_W];
    int                    last_writer [2**REG_ADDR_W];
    bit                    seen [2**SEQ_W];
    int                    n_legal;
    int                    n_ill;
    int                    n_done;
    int                    ill_seen;
    int                    err_check;
    int                    err_other;
    int                    cycle_cnt;
    bit                    saw_full;
    logic                  dep_ok;

    backend_top i_dut (
        .clk(clk), .rst(rst),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .full_o(full_o), .illegal_o(illegal_o),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o), .wb_seq_o(wb_seq_o),
        .rf_raddr_i(rf_raddr_i), .rf_rdata_o(rf_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // RV32I semantics straight from the ISA spec
    function automatic logic [XLEN-1:0] ref_alu(input logic [2:0] f3, input bit alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [XLEN-1:0] res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 1 : 0;
            3'd3: res = (a < b) ? 1 : 0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else     res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic record_legal(input logic [REG_ADDR_W-1:0] rd, input int p1, input int p2,
                                input logic [XLEN-1:0] res);
        exp_rd[n_legal]   = rd;
        exp_data[n_legal] = res;
        prod1[n_legal]    = p1;
        prod2[n_legal]    = p2;
        if (rd != '0) begin
            ref_rf[rd]      = res;
            last_writer[rd] = n_legal;
        end
        n_legal++;
    endtask

    task automatic build_program();
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [2:0]            f3;
        logic [11:0]           imm;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        bit                    alt;
        int                    kind;
        for (int r = 0; r < 2**REG_ADDR_W; r++) begin
            ref_rf[r]      = '0;
            last_writer[r] = -1;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rd   = REG_ADDR_W'($urandom_range(0, NUM_REGS - 1));
            rs1  = REG_ADDR_W'($urandom_range(0, NUM_REGS - 1));
            rs2  = REG_ADDR_W'($urandom_range(0, NUM_REGS - 1));
            f3   = 3'($urandom_range(0, 7));
            kind = $urandom_range(0, 19);
            imm  = 12'($urandom);
            if (i < 4) begin
                // addi x1..x4 from x0, about half get negative immediates
                kind = 10;
                rd   = REG_ADDR_W'(i + 1);
                rs1  = '0;
                f3   = F3_ADD_SUB;
            end else if (i < 10) begin
                // mul chain on x1 stalls issue and backs up the queue
                kind = 2;
                rd   = 5'd1;
                rs1  = 5'd1;
                rs2  = 5'd2;
            end
            alt = $urandom_range(0, 1) && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA);
            a   = ref_rf[rs1];
            b   = ref_rf[rs2];
            if (kind == 0) begin
                case ($urandom_range(0, 2))
                    0:       prog[i] = {25'($urandom), 7'b0000011};  // load opcode
                    1:       prog[i] = {F7_MULDIV, rs2, rs1, F3_SLL, rd, OPC_OP};  // mulh
                    default: prog[i] = {F7_ALT, rs2, rs1, F3_SLL, rd, OPC_OP};
                endcase
                n_ill++;
            end else if (kind < 4) begin
                prog[i] = {F7_MULDIV, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
                record_legal(rd, last_writer[rs1], last_writer[rs2], a * b);
            end else if (kind < 10) begin
                prog[i] = {alt ? F7_ALT : F7_BASE, rs2, rs1, f3, rd, OPC_OP};
                record_legal(rd, last_writer[rs1], last_writer[rs2], ref_alu(f3, alt, a, b));
            end else begin
                if (f3 == F3_SRL_SRA) begin
                    imm = {alt ? F7_ALT : F7_BASE, imm[4:0]};
                end else begin
                    if (f3 == F3_SLL) imm = {F7_BASE, imm[4:0]};
                    alt = 1'b0;
                end
                prog[i] = {imm, rs1, f3, rd, OPC_OP_IMM};
                record_legal(rd, last_writer[rs1], -1,
                             ref_alu(f3, alt, a, {{(XLEN-12){imm[11]}}, imm}));
            end
        end
    endtask

    task automatic push_program();
        int idx;
        idx = 0;
        while (idx < PROG_LEN) begin
            @(negedge clk);
            if (full_o) begin
                inst_valid_i = 1'b0;
                saw_full     = 1'b1;
            end else begin
                inst_valid_i = 1'b1;
                inst_i       = prog[idx];
                idx++;
            end
        end
        @(negedge clk);
        inst_valid_i = 1'b0;
    endtask

    task automatic check_registers();
        for (int r = 0; r < 2**REG_ADDR_W; r++) begin
            @(negedge clk);
            rf_raddr_i = REG_ADDR_W'(r);
            @(posedge clk);
            assert (rf_rdata_o === ref_rf[r]) else begin
                err_check++;
                $display("CHECK FAILED t=%0t rf_rdata_o (x%0d) expected %h actual %h",
                         $time, r, ref_rf[r], rf_rdata_o);
            end
        end
        @(negedge clk);
        rf_raddr_i = '0;
    endtask

    task automatic print_summary();
        $display("summary: %0d value check failures, %0d other failures, %0d of %0d completed",
                 err_check, err_other, n_done, n_legal);
    endtask

    // bookkeeping of completions and illegal pulses
    always @(posedge clk) begin
        if (!rst && wb_valid_o) begin
            seen[wb_seq_o] <= 1'b1;
            n_done         <= n_done + 1;
        end
        if (!rst && illegal_o) begin
            ill_seen <= ill_seen + 1;
        end
    end

    assign dep_ok = (prod1[wb_seq_o] < 0 || seen[prod1[wb_seq_o]])
                 && (prod2[wb_seq_o] < 0 || seen[prod2[wb_seq_o]]);

    assert property (@(posedge clk) disable iff (rst) wb_valid_o |-> int'(wb_seq_o) < n_legal)
        else begin
            err_check++;
            $display("CHECK FAILED t=%0t wb_seq_o expected below %0d actual %0d",
                     $time, n_legal, $sampled(wb_seq_o));
        end

    assert property (@(posedge clk) disable iff (rst) wb_valid_o |-> wb_rd_o == exp_rd[wb_seq_o])
        else begin
            err_check++;
            $display("CHECK FAILED t=%0t wb_rd_o expected %0d actual %0d", $time,
                     exp_rd[$sampled(wb_seq_o)], $sampled(wb_rd_o));
        end

    assert property (@(posedge clk) disable iff (rst)
                     wb_valid_o |-> wb_data_o == exp_data[wb_seq_o])
        else begin
            err_check++;
            $display("CHECK FAILED t=%0t wb_data_o expected %h actual %h", $time,
                     exp_data[$sampled(wb_seq_o)], $sampled(wb_data_o));
        end

    assert property (@(posedge clk) disable iff (rst) wb_valid_o |-> !seen[wb_seq_o])
        else begin
            err_other++;
            $display("sequence number %0d completed more than once at %0t",
                     $sampled(wb_seq_o), $time);
        end

    assert property (@(posedge clk) disable iff (rst) wb_valid_o |-> dep_ok)
        else begin
            err_other++;
            $display("sequence number %0d completed before its producer at %0t",
                     $sampled(wb_seq_o), $time);
        end

    assert property (@(posedge clk) disable iff (rst) rf_raddr_i == '0 |-> rf_rdata_o == '0)
        else begin
            err_check++;
            $display("CHECK FAILED t=%0t rf_rdata_o (x0) expected 0 actual %h",
                     $time, $sampled(rf_rdata_o));
        end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not drain within %0d cycles", TIMEOUT_CYCLES);
            print_summary();
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        rf_raddr_i   = '0;
        void'($urandom(51));
        build_program();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        push_program();
        while (n_done < n_legal || ill_seen < n_ill) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);  // room for any stray completion
        check_registers();
        assert (n_done == n_legal) else begin
            err_other++;
            $display("%0d completions seen for %0d legal instructions", n_done, n_legal);
        end
        assert (ill_seen == n_ill) else begin
            err_other++;
            $display("illegal_o pulsed %0d times for %0d illegal words", ill_seen, n_ill);
        end
        assert (saw_full) else begin
            err_other++;
            $display("full_o never rose while the program was pushed back to back");
        end
        print_summary();
        if (err_check + err_other == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- hdl/backend_top.sv
`timescale 1ns/1ps

module backend_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                inst_valid_i,
    input  logic [rv32_isa_pkg::XLEN-1:0]       inst_i,
    output logic                                full_o,
    output logic                                illegal_o,
    output logic                                wb_valid_o,
    output logic [rv32_isa_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv32_isa_pkg::XLEN-1:0]       wb_data_o,
    output logic [core_ctrl_pkg::SEQ_W-1:0]     wb_seq_o,
    input  logic [rv32_isa_pkg::REG_ADDR_W-1:0] rf_raddr_i,
    output logic [rv32_isa_pkg::XLEN-1:0]       rf_rdata_o
);
    import rv32_isa_pkg::*;
    import core_ctrl_pkg::*;

    fetch_pkt_t               push_pkt;
    fetch_pkt_t               head_pkt;
    logic                     empty;
    logic                     pop;
    logic [REG_ADDR_W-1:0]    rs1_addr;
    logic [REG_ADDR_W-1:0]    rs2_addr;
    logic [XLEN-1:0]          rs1_rdata;
    logic [XLEN-1:0]          rs2_rdata;
    logic [2**REG_ADDR_W-1:0] pending;
    logic                     set_pending;
    logic [REG_ADDR_W-1:0]    set_rd;
    logic                     alu_issue;
    logic                     mul_issue;
    uop_t                     uop;
    logic                     alu_done;
    logic [REG_ADDR_W-1:0]    alu_rd;
    logic [XLEN-1:0]          alu_data;
    logic [SEQ_W-1:0]         alu_seq;
    logic                     mul_done;
    logic [REG_ADDR_W-1:0]    mul_rd;
    logic [XLEN-1:0]          mul_data;
    logic [SEQ_W-1:0]         mul_seq;
    logic                     mul_wb_next;

    assign push_pkt.inst = inst_i;

    inst_queue i_queue (
        .clk(clk), .rst(rst),
        .push_i(inst_valid_i), .push_pkt_i(push_pkt),
        .pop_i(pop), .head_pkt_o(head_pkt),
        .empty_o(empty), .full_o(full_o)
    );

    decode_issue i_decode (
        .clk(clk), .rst(rst),
        .head_pkt_i(head_pkt), .empty_i(empty),
        .rs1_rdata_i(rs1_rdata), .rs2_rdata_i(rs2_rdata),
        .pending_i(pending), .mul_wb_next_i(mul_wb_next),
        .pop_o(pop), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .set_pending_o(set_pending), .set_rd_o(set_rd),
        .alu_issue_o(alu_issue), .mul_issue_o(mul_issue),
        .uop_o(uop), .illegal_o(illegal_o)
    );

    execute_units i_execute (
        .clk(clk), .rst(rst),
        .alu_issue_i(alu_issue), .mul_issue_i(mul_issue), .uop_i(uop),
        .alu_done_o(alu_done), .alu_rd_o(alu_rd), .alu_data_o(alu_data), .alu_seq_o(alu_seq),
        .mul_done_o(mul_done), .mul_rd_o(mul_rd), .mul_data_o(mul_data), .mul_seq_o(mul_seq),
        .mul_wb_next_o(mul_wb_next)
    );

    result_writeback i_result (
        .clk(clk), .rst(rst),
        .alu_done_i(alu_done), .alu_rd_i(alu_rd), .alu_data_i(alu_data), .alu_seq_i(alu_seq),
        .mul_done_i(mul_done), .mul_rd_i(mul_rd), .mul_data_i(mul_data), .mul_seq_i(mul_seq),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .set_pending_i(set_pending), .set_rd_i(set_rd), .rf_raddr_i(rf_raddr_i),
        .rs1_rdata_o(rs1_rdata), .rs2_rdata_o(rs2_rdata), .pending_o(pending),
        .rf_rdata_o(rf_rdata_o),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o), .wb_seq_o(wb_seq_o)
    );

endmodule

//--- hdl/result_writeback.sv
`timescale 1ns/1ps

module result_writeback (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   alu_done_i,
    input  logic [rv32_isa_pkg::REG_ADDR_W-1:0]    alu_rd_i,
    input  logic [rv32_isa_pkg::XLEN-1:0]          alu_data_i,
    input  logic [core_ctrl_pkg::SEQ_W-1:0]        alu_seq_i,
    input  logic                                   mul_done_i,
    input  logic [rv32_isa_pkg::REG_ADDR_W-1:0]    mul_rd_i,
    input  logic [rv32_isa_pkg::XLEN-1:0]          mul_data_i,
    input  logic [core_ctrl_pkg::SEQ_W-1:0]        mul_seq_i,
    input  logic [rv32_isa_pkg::REG_ADDR_W-1:0]    rs1_addr_i,
    input  logic [rv32_isa_pkg::REG_ADDR_W-1:0]    rs2_addr_i,
    input  logic                                   set_pending_i,
    input  logic [rv32_isa_pkg::REG_ADDR_W-1:0]    set_rd_i,
    input  logic [rv32_isa_pkg::REG_ADDR_W-1:0]    rf_raddr_i,
    output logic [rv32_isa_pkg::XLEN-1:0]          rs1_rdata_o,
    output logic [rv32_isa_pkg::XLEN-1:0]          rs2_rdata_o,
    output logic [2**rv32_isa_pkg::REG_ADDR_W-1:0] pending_o,
    output logic [rv32_isa_pkg::XLEN-1:0]          rf_rdata_o,
    output logic                                   wb_valid_o,
    output logic [rv32_isa_pkg::REG_ADDR_W-1:0]    wb_rd_o,
    output logic [rv32_isa_pkg::XLEN-1:0]          wb_data_o,
    output logic [core_ctrl_pkg::SEQ_W-1:0]        wb_seq_o
);
    import rv32_isa_pkg::*;

    logic [XLEN-1:0]              rf_q [2**REG_ADDR_W];
    logic [2**REG_ADDR_W-1:0]     pending_q;

    // decode keeps alu and mul completions apart
    assign wb_valid_o = alu_done_i || mul_done_i;
    assign wb_rd_o    = alu_done_i ? alu_rd_i   : mul_rd_i;
    assign wb_data_o  = alu_done_i ? alu_data_i : mul_data_i;
    assign wb_seq_o   = alu_done_i ? alu_seq_i  : mul_seq_i;

    assign rs1_rdata_o = rf_q[rs1_addr_i];
    assign rs2_rdata_o = rf_q[rs2_addr_i];
    assign rf_rdata_o  = rf_q[rf_raddr_i];
    assign pending_o   = pending_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                rf_q[i] <= '0;
            end
            pending_q <= '0;
        end else begin
            if (wb_valid_o && (wb_rd_o != '0)) begin
                rf_q[wb_rd_o] <= wb_data_o; // x0 stays zero
            end
            if (set_pending_i) begin
                pending_q[set_rd_i] <= 1'b1;
            end
            if (wb_valid_o) begin
                pending_q[wb_rd_o] <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/execute_units.sv
`timescale 1ns/1ps

module execute_units (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                alu_issue_i,
    input  logic                                mul_issue_i,
    input  core_ctrl_pkg::uop_t                 uop_i,
    output logic                                alu_done_o,
    output logic [rv32_isa_pkg::REG_ADDR_W-1:0] alu_rd_o,
    output logic [rv32_isa_pkg::XLEN-1:0]       alu_data_o,
    output logic [core_ctrl_pkg::SEQ_W-1:0]     alu_seq_o,
    output logic                                mul_done_o,
    output logic [rv32_isa_pkg::REG_ADDR_W-1:0] mul_rd_o,
    output logic [rv32_isa_pkg::XLEN-1:0]       mul_data_o,
    output logic [core_ctrl_pkg::SEQ_W-1:0]     mul_seq_o,
    output logic                                mul_wb_next_o
);
    import rv32_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [XLEN-1:0]       alu_result;
    logic [4:0]            shamt;
    logic [MUL_STAGES-1:0] mul_v_q;
    logic [REG_ADDR_W-1:0] mul_rd_q [MUL_STAGES];
    logic [SEQ_W-1:0]      mul_seq_q [MUL_STAGES];
    logic [XLEN-1:0]       pp_lo_q;
    logic [XLEN-1:0]       pp_hi_q;
    logic [XLEN-1:0]       sum_q;
    logic [XLEN-1:0]       prod_q;

    assign shamt = uop_i.src2[4:0];

    always_comb begin
        case (uop_i.op)
            ALU_SUB:  alu_result = uop_i.src1 - uop_i.src2;
            ALU_SLL:  alu_result = uop_i.src1 << shamt;
            ALU_SLT:  alu_result = XLEN'($signed(uop_i.src1) < $signed(uop_i.src2));
            ALU_SLTU: alu_result = XLEN'(uop_i.src1 < uop_i.src2);
            ALU_XOR:  alu_result = uop_i.src1 ^ uop_i.src2;
            ALU_SRL:  alu_result = uop_i.src1 >> shamt;
            ALU_SRA:  alu_result = $signed(uop_i.src1) >>> shamt;
            ALU_OR:   alu_result = uop_i.src1 | uop_i.src2;
            ALU_AND:  alu_result = uop_i.src1 & uop_i.src2;
            default:  alu_result = uop_i.src1 + uop_i.src2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_done_o <= 1'b0;
            mul_v_q    <= '0;
        end else begin
            alu_done_o <= alu_issue_i;
            mul_v_q    <= {mul_v_q[MUL_STAGES-2:0], mul_issue_i};
        end
    end

    always_ff @(posedge clk) begin
        alu_rd_o   <= uop_i.rd;
        alu_seq_o  <= uop_i.seq;
        alu_data_o <= alu_result;
        // low half of the product from two 16-bit slices of src2
        pp_lo_q    <= uop_i.src1 * uop_i.src2[XLEN/2-1:0];
        pp_hi_q    <= (uop_i.src1 * uop_i.src2[XLEN-1:XLEN/2]) << (XLEN/2);
        sum_q      <= pp_lo_q + pp_hi_q;
        prod_q     <= sum_q;
        mul_rd_q[0]  <= uop_i.rd;
        mul_seq_q[0] <= uop_i.seq;
        for (int i = 1; i < MUL_STAGES; i++) begin
            mul_rd_q[i]  <= mul_rd_q[i-1];
            mul_seq_q[i] <= mul_seq_q[i-1];
        end
    end

    assign mul_wb_next_o = mul_v_q[1]; // completes next cycle
    assign mul_done_o    = mul_v_q[MUL_STAGES-1];
    assign mul_rd_o      = mul_rd_q[MUL_STAGES-1];
    assign mul_seq_o     = mul_seq_q[MUL_STAGES-1];
    assign mul_data_o    = prod_q;

endmodule

//--- hdl/decode_issue.sv
`timescale 1ns/1ps

module decode_issue (
    input  logic                                    clk,
    input  logic                                    rst,
    input  core_ctrl_pkg::fetch_pkt_t               head_pkt_i,
    input  logic                                    empty_i,
    input  logic [rv32_isa_pkg::XLEN-1:0]           rs1_rdata_i,
    input  logic [rv32_isa_pkg::XLEN-1:0]           rs2_rdata_i,
    input  logic [2**rv32_isa_pkg::REG_ADDR_W-1:0]  pending_i,
    input  logic                                    mul_wb_next_i,
    output logic                                    pop_o,
    output logic [rv32_isa_pkg::REG_ADDR_W-1:0]     rs1_addr_o,
    output logic [rv32_isa_pkg::REG_ADDR_W-1:0]     rs2_addr_o,
    output logic                                    set_pending_o,
    output logic [rv32_isa_pkg::REG_ADDR_W-1:0]     set_rd_o,
    output logic                                    alu_issue_o,
    output logic                                    mul_issue_o,
    output core_ctrl_pkg::uop_t                     uop_o,
    output logic                                    illegal_o
);
    import rv32_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_sext;
    alu_op_e               base_op;
    alu_op_e               op;
    logic                  legal;
    logic                  is_mul;
    logic                  use_rs2;
    logic                  head_valid;
    logic                  stall;
    logic                  issue;
    logic [SEQ_W-1:0]      seq_q;

    assign opcode     = head_pkt_i.inst[6:0];
    assign rd         = head_pkt_i.inst[11:7];
    assign funct3     = head_pkt_i.inst[14:12];
    assign rs1_addr_o = head_pkt_i.inst[19:15];
    assign rs2_addr_o = head_pkt_i.inst[24:20];
    assign funct7     = head_pkt_i.inst[31:25];
    assign imm_sext   = {{(XLEN-12){head_pkt_i.inst[31]}}, head_pkt_i.inst[31:20]};
    assign use_rs2    = (opcode == OPC_OP);

    always_comb begin
        case (funct3)
            F3_SLL:     base_op = ALU_SLL;
            F3_SLT:     base_op = ALU_SLT;
            F3_SLTU:    base_op = ALU_SLTU;
            F3_XOR:     base_op = ALU_XOR;
            F3_SRL_SRA: base_op = ALU_SRL;
            F3_OR:      base_op = ALU_OR;
            F3_AND:     base_op = ALU_AND;
            default:    base_op = ALU_ADD;
        endcase
    end

    always_comb begin
        legal  = 1'b1;
        is_mul = 1'b0;
        op     = base_op;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_MULDIV) begin
                    is_mul = 1'b1;
                    legal  = (funct3 == F3_ADD_SUB); // mul only, no mulh or div
                end else if (funct7 == F7_ALT) begin
                    legal = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);
                    op    = (funct3 == F3_ADD_SUB) ? ALU_SUB : ALU_SRA;
                end else begin
                    legal = (funct7 == F7_BASE);
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == F3_SLL) begin
                    legal = (funct7 == F7_BASE);
                end else if (funct3 == F3_SRL_SRA) begin
                    legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    op    = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                end
            end
            default: legal = 1'b0;
        endcase
    end

    // x0 is never pending, so no extra check on index zero
    assign stall = pending_i[rs1_addr_o] || (use_rs2 && pending_i[rs2_addr_o])
                || pending_i[rd] || (!is_mul && mul_wb_next_i);

    assign head_valid    = !empty_i;
    assign issue         = head_valid && legal && !stall;
    assign illegal_o     = head_valid && !legal;
    assign pop_o         = issue || illegal_o; // illegal words are dropped
    assign alu_issue_o   = issue && !is_mul;
    assign mul_issue_o   = issue && is_mul;
    assign set_pending_o = issue && (rd != '0);
    assign set_rd_o      = rd;

    assign uop_o.op   = op;
    assign uop_o.src1 = rs1_rdata_i;
    assign uop_o.src2 = use_rs2 ? rs2_rdata_i : imm_sext;
    assign uop_o.rd   = rd;
    assign uop_o.seq  = seq_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_q <= '0;
        end else if (issue) begin
            seq_q <= seq_q + 1'b1;
        end
    end

endmodule

//--- hdl/inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push_i,
    input  core_ctrl_pkg::fetch_pkt_t push_pkt_i,
    input  logic                     pop_i,
    output core_ctrl_pkg::fetch_pkt_t head_pkt_o,
    output logic                     empty_o,
    output logic                     full_o
);
    import core_ctrl_pkg::*;

    fetch_pkt_t                      mem [IQ_DEPTH];
    logic [$clog2(IQ_DEPTH)-1:0]     wr_ptr_q;
    logic [$clog2(IQ_DEPTH)-1:0]     rd_ptr_q;
    logic [$clog2(IQ_DEPTH+1)-1:0]   count_q;
    logic                            do_push;
    logic                            do_pop;

    assign do_push    = push_i && !full_o; // push while full is dropped
    assign do_pop     = pop_i && !empty_o;
    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == IQ_DEPTH);
    assign head_pkt_o = mem[rd_ptr_q];     // fall-through head

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_pkt_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- hdl/core_ctrl_pkg.sv
package core_ctrl_pkg;

    localparam int SEQ_W      = 8;  // wraps
    localparam int IQ_DEPTH   = 8;
    localparam int MUL_STAGES = 3;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [rv32_isa_pkg::XLEN-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        alu_op_e                             op;
        logic [rv32_isa_pkg::XLEN-1:0]       src1;
        logic [rv32_isa_pkg::XLEN-1:0]       src2;   // rs2 or immediate
        logic [rv32_isa_pkg::REG_ADDR_W-1:0] rd;
        logic [SEQ_W-1:0]                    seq;
    } uop_t;

endpackage

//--- hdl/rv32_isa_pkg.sv
package rv32_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001; // m extension

endpackage
